/* Makefile */
# Verilator simulation of the Z80 expansion-bus core

VERILATOR ?= verilator
TOP       ?= tb_zbus_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+include
logic/zbus_pkg.sv
logic/zbus_ctrl.sv
logic/bank_map.sv
logic/sys_regs.sv
logic/keyboard.sv
logic/zbus_top.sv
tests/tb_zbus_top.sv

/* logic/bank_map.sv */
`timescale 1ns/10ps

module bank_map
    import zbus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  bus_req_t          bus,
    input  io_sel_e           io_sel,
    input  logic [DATA_W-1:0] wrdata,
    input  logic              wr_stb,
    output logic [DATA_W-1:0] bank_rd,
    output mem_sel_t          mem_sel
);

    bank_reg_t bank_r [4];
    bank_reg_t bank_cur;        // Bank of the current address

    logic sel_sysram;
    logic sel_window;
    logic reserved;
    logic allow_mem;
    logic sel_cart;
    logic sel_ram;

    ////////////////////////////////////////////////////////////
    // Bank registers $F0-$F3
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_r[0] <= BANK_RESET_0;
            bank_r[1] <= BANK_RESET_1;
            bank_r[2] <= BANK_RESET_2;
            bank_r[3] <= BANK_RESET_3;
        end else if (wr_stb && io_sel == IO_BANK) begin
            bank_r[bus.a[1:0]] <= bank_reg_t'(wrdata);
        end
    end

    assign bank_rd  = bank_r[bus.a[1:0]];
    assign bank_cur = bank_r[bus.a[15:14]];

    ////////////////////////////////////////////////////////////
    // Memory decoding
    ////////////////////////////////////////////////////////////
    assign sel_sysram = !bus.mreq_n && bank_cur.overlay && bus.a[13:11] == 3'b111;
    assign sel_window = bank_cur.overlay && bus.a[13:11] == 3'b110;    // $3000-$37FF

    // Former internal memories where nobody answers
    assign reserved = bank_cur.page <= PAGE_RES_ROM_LAST ||
                      bank_cur.page == PAGE_RES_VRAM ||
                      bank_cur.page == PAGE_RES_CHRAM ||
                      sel_window;

    assign allow_mem = !bus.mreq_n && !sel_sysram && !reserved &&
                       (bus.wr_n || !bank_cur.ro);

    assign sel_cart = allow_mem &&
                      bank_cur.page[PAGE_W-1:2] == PAGE_CART_FIRST[PAGE_W-1:2];
    assign sel_ram  = (allow_mem && bank_cur.page[PAGE_W-1]) || sel_sysram;

    always_comb begin
        mem_sel.ram_ce_n  = !sel_ram;
        mem_sel.cart_ce_n = !sel_cart;
        mem_sel.ram_we_n  = !(!bus.wr_n && sel_ram);
        mem_sel.ba        = sel_sysram ? '0 : bank_cur.page[BA_W-1:0];  // System RAM in page 32
    end

endmodule

/* logic/keyboard.sv */
`timescale 1ns/10ps

module keyboard
    import zbus_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  bus_req_t                  bus,
    input  io_sel_e                   io_sel,
    input  logic [DATA_W-1:0]         wrdata,
    input  logic                      wr_stb,
    input  logic                      rd_stb,
    input  logic [KB_ROWS*DATA_W-1:0] keys,
    input  logic [DATA_W-1:0]         kb_data,
    input  logic                      kb_wren,
    output logic [DATA_W-1:0]         kbbuf_rd,
    output logic [DATA_W-1:0]         keyb_rd
);

    logic [DATA_W-1:0]   fifo_mem [KBBUF_DEPTH];
    logic [KB_PTR_W-1:0] wr_ptr;
    logic [KB_PTR_W-1:0] rd_ptr;
    logic [KB_PTR_W:0]   count;
    logic [DATA_W-1:0]   head;
    logic [DATA_W-1:0]   rd_hold;       // Byte returned by the current read
    logic                hold_valid;
    logic                fifo_empty;
    logic                fifo_full;
    logic                kb_read;
    logic                push;
    logic                pop;
    logic                flush;

    // A low address bit selects its key row
    always_comb begin
        keyb_rd = '1;
        for (int i = 0; i < KB_ROWS; i++) begin
            if (!bus.a[8+i]) begin
                keyb_rd &= keys[DATA_W*i +: DATA_W];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Keyboard buffer FIFO at $FA
    ////////////////////////////////////////////////////////////
    assign fifo_empty = count == '0;
    assign fifo_full  = count == (KB_PTR_W+1)'(KBBUF_DEPTH);
    assign kb_read    = rd_stb && io_sel == IO_KBBUF;
    assign flush      = wr_stb && io_sel == IO_KBBUF;   // Any byte written clears it
    assign push       = kb_wren && !fifo_full;          // Dropped when full
    assign pop        = kb_read && !fifo_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= kb_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    assign head = fifo_empty ? '0 : fifo_mem[rd_ptr];

    // Pop comes early in the cycle so the popped byte is kept until rd_n rises
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (kb_read) begin
            hold_valid <= 1'b1;
        end else if (bus.rd_n) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (kb_read) begin
            rd_hold <= head;
        end
    end

    assign kbbuf_rd = hold_valid ? rd_hold : head;

endmodule

/* logic/sys_regs.sv */
`timescale 1ns/10ps

module sys_regs
    import zbus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  io_sel_e           io_sel,
    input  logic [DATA_W-1:0] wrdata,
    input  logic              wr_stb,
    input  logic              cassette_in,
    input  logic              printer_in,
    input  logic              vblank,
    output sys_ctrl_t         sys_ctrl,
    output logic              cpm_remap,
    output logic              cassette_out,
    output logic              printer_out,
    output logic [DATA_W-1:0] sys_rd
);

    logic [2:0] cassette_sync;
    logic [2:0] printer_sync;

    ////////////////////////////////////////////////////////////
    // Write side of $FB-$FE
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sys_ctrl     <= '0;
            cassette_out <= 1'b0;
            cpm_remap    <= 1'b0;
            printer_out  <= 1'b0;
        end else if (wr_stb) begin
            case (io_sel)
                IO_SYSCTRL:   sys_ctrl     <= sys_ctrl_t'(wrdata[2:0]);
                IO_CASSETTE:  cassette_out <= wrdata[0];
                IO_VSYNC_CPM: cpm_remap    <= wrdata[0];
                IO_PRINTER:   printer_out  <= wrdata[0];
                default:      ;
            endcase
        end
    end

    // Async inputs into the clk domain
    always_ff @(posedge clk) begin
        cassette_sync <= {cassette_sync[1:0], cassette_in};
        printer_sync  <= {printer_sync[1:0], printer_in};
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (io_sel)
            IO_SYSCTRL:   sys_rd = {5'b0, sys_ctrl};
            IO_CASSETTE:  sys_rd = {7'b0, !cassette_sync[2]};  // Inverted on the board
            IO_VSYNC_CPM: sys_rd = {7'b0, !vblank};
            IO_PRINTER:   sys_rd = {7'b0, printer_sync[2]};
            default:      sys_rd = '0;
        endcase
    end

endmodule

/* logic/zbus_ctrl.sv */
`timescale 1ns/10ps

module zbus_ctrl
    import zbus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  bus_req_t          bus,
    input  logic [DATA_W-1:0] d_in,
    input  sys_ctrl_t         sys_ctrl,
    input  logic [DATA_W-1:0] bank_rd,
    input  logic [DATA_W-1:0] sys_rd,
    input  logic [DATA_W-1:0] kbbuf_rd,
    input  logic [DATA_W-1:0] keyb_rd,
    output io_sel_e           io_sel,
    output logic [DATA_W-1:0] wrdata,
    output logic              wr_stb,
    output logic              rd_stb,
    output logic [DATA_W-1:0] d_out,
    output logic              d_oe
);

    logic [2:0] wr_n_sync;
    logic [2:0] rd_n_sync;

    ////////////////////////////////////////////////////////////
    // Strobe synchronizers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= 3'b111;    // Idle high so reset gives no stray pulse
            rd_n_sync <= 3'b111;
        end else begin
            wr_n_sync <= {wr_n_sync[1:0], bus.wr_n};
            rd_n_sync <= {rd_n_sync[1:0], bus.rd_n};
        end
    end

    // One pulse per falling edge
    assign wr_stb = wr_n_sync[2:1] == 2'b10;
    assign rd_stb = rd_n_sync[2:1] == 2'b10;

    // Data stays valid through the whole low phase of wr_n
    always_ff @(posedge clk) begin
        if (!bus.wr_n) begin
            wrdata <= d_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Port decoding
    ////////////////////////////////////////////////////////////
    always_comb begin
        io_sel = IO_NONE;
        if (!bus.iorq_n) begin
            case (bus.a[7:0])
                PORT_BANK0, PORT_BANK1, PORT_BANK2, PORT_BANK3:
                    io_sel = sys_ctrl.dis_regs ? IO_NONE : IO_BANK;
                PORT_KBBUF:     io_sel = IO_KBBUF;
                PORT_SYSCTRL:   io_sel = IO_SYSCTRL;
                PORT_CASSETTE:  io_sel = IO_CASSETTE;
                PORT_VSYNC_CPM: io_sel = IO_VSYNC_CPM;
                PORT_PRINTER:   io_sel = IO_PRINTER;
                PORT_KEYB:      io_sel = IO_KEYB;
                default:        io_sel = IO_NONE;   // Other ports left to the bus
            endcase
        end
    end

    // Read data from the owner of the port
    always_comb begin
        case (io_sel)
            IO_BANK:      d_out = bank_rd;
            IO_KBBUF:     d_out = kbbuf_rd;
            IO_SYSCTRL,
            IO_CASSETTE,
            IO_VSYNC_CPM,
            IO_PRINTER:   d_out = sys_rd;
            IO_KEYB:      d_out = keyb_rd;
            default:      d_out = '0;
        endcase
    end

    assign d_oe = !bus.rd_n && (io_sel != IO_NONE);

endmodule

/* logic/zbus_pkg.sv */
package zbus_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////
    localparam int DATA_W      = 8;
    localparam int ADDR_W      = 16;
    localparam int PAGE_W      = 6;             // 64 pages of 16KB
    localparam int BA_W        = 5;             // External page lines
    localparam int KBBUF_DEPTH = 16;
    localparam int KB_PTR_W    = $clog2(KBBUF_DEPTH);
    localparam int KB_ROWS     = 8;             // One matrix row per a[15:8] bit

    // I/O ports on the low address byte
    localparam logic [7:0] PORT_BANK0      = 8'hF0;
    localparam logic [7:0] PORT_BANK1      = 8'hF1;
    localparam logic [7:0] PORT_BANK2      = 8'hF2;
    localparam logic [7:0] PORT_BANK3      = 8'hF3;
    localparam logic [7:0] PORT_KBBUF      = 8'hFA;
    localparam logic [7:0] PORT_SYSCTRL    = 8'hFB;
    localparam logic [7:0] PORT_CASSETTE   = 8'hFC;
    localparam logic [7:0] PORT_VSYNC_CPM  = 8'hFD;
    localparam logic [7:0] PORT_PRINTER    = 8'hFE;
    localparam logic [7:0] PORT_KEYB       = 8'hFF;

    // Page numbers seen by the memory decoder
    localparam logic [PAGE_W-1:0] PAGE_RES_ROM_LAST = 6'd3;    // Pages 0-3 held the ROM
    localparam logic [PAGE_W-1:0] PAGE_CART_FIRST   = 6'd16;   // 16-19
    localparam logic [PAGE_W-1:0] PAGE_RES_VRAM     = 6'd20;
    localparam logic [PAGE_W-1:0] PAGE_RES_CHRAM    = 6'd21;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              ro;          // Block writes
        logic              overlay;     // Map $3000-$3FFF of the bank
        logic [PAGE_W-1:0] page;
    } bank_reg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] a;
        logic              rd_n;
        logic              wr_n;
        logic              mreq_n;
        logic              iorq_n;
    } bus_req_t;

    typedef struct packed {
        logic            ram_ce_n;
        logic            cart_ce_n;
        logic            ram_we_n;
        logic [BA_W-1:0] ba;
    } mem_sel_t;

    typedef struct packed {
        logic turbo;
        logic dis_psgs;
        logic dis_regs;             // Hides the bank ports
    } sys_ctrl_t;

    typedef enum logic [3:0] {
        IO_NONE      = 4'd0,
        IO_BANK      = 4'd1,
        IO_KBBUF     = 4'd2,
        IO_SYSCTRL   = 4'd3,
        IO_CASSETTE  = 4'd4,
        IO_VSYNC_CPM = 4'd5,
        IO_PRINTER   = 4'd6,
        IO_KEYB      = 4'd7
    } io_sel_e;

    // Bank registers after reset
    localparam bank_reg_t BANK_RESET_0 = 8'hC0;     // RO and overlay on page 0
    localparam bank_reg_t BANK_RESET_1 = {2'b00, 6'd33};
    localparam bank_reg_t BANK_RESET_2 = {2'b00, 6'd34};
    localparam bank_reg_t BANK_RESET_3 = {2'b00, 6'd19};

endpackage

/* logic/zbus_top.sv */
`timescale 1ns/10ps

module zbus_top
    import zbus_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  bus_req_t                  bus,
    input  logic [DATA_W-1:0]         d_in,
    input  logic [KB_ROWS*DATA_W-1:0] keys,
    input  logic [DATA_W-1:0]         kb_data,
    input  logic                      kb_wren,
    input  logic                      cassette_in,
    input  logic                      printer_in,
    input  logic                      vblank,
    output logic [DATA_W-1:0]         d_out,
    output logic                      d_oe,
    output mem_sel_t                  mem_sel,
    output logic                      cassette_out,
    output logic                      printer_out,
    output logic                      cpm_remap
);

    io_sel_e           io_sel;
    sys_ctrl_t         sys_ctrl;
    logic [DATA_W-1:0] wrdata;
    logic              wr_stb;
    logic              rd_stb;
    logic [DATA_W-1:0] bank_rd;
    logic [DATA_W-1:0] sys_rd;
    logic [DATA_W-1:0] kbbuf_rd;
    logic [DATA_W-1:0] keyb_rd;

    ////////////////////////////////////////////////////////////
    // Bus control and port select
    ////////////////////////////////////////////////////////////
    zbus_ctrl i_zbus_ctrl (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .d_in     (d_in),
        .sys_ctrl (sys_ctrl),
        .bank_rd  (bank_rd),
        .sys_rd   (sys_rd),
        .kbbuf_rd (kbbuf_rd),
        .keyb_rd  (keyb_rd),
        .io_sel   (io_sel),
        .wrdata   (wrdata),
        .wr_stb   (wr_stb),
        .rd_stb   (rd_stb),
        .d_out    (d_out),
        .d_oe     (d_oe)
    );

    ////////////////////////////////////////////////////////////
    // Datapath blocks
    ////////////////////////////////////////////////////////////
    bank_map i_bank_map (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus),
        .io_sel  (io_sel),
        .wrdata  (wrdata),
        .wr_stb  (wr_stb),
        .bank_rd (bank_rd),
        .mem_sel (mem_sel)
    );

    sys_regs i_sys_regs (
        .clk          (clk),
        .reset        (reset),
        .io_sel       (io_sel),
        .wrdata       (wrdata),
        .wr_stb       (wr_stb),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .vblank       (vblank),
        .sys_ctrl     (sys_ctrl),
        .cpm_remap    (cpm_remap),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .sys_rd       (sys_rd)
    );

    keyboard i_keyboard (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .io_sel   (io_sel),
        .wrdata   (wrdata),
        .wr_stb   (wr_stb),
        .rd_stb   (rd_stb),
        .keys     (keys),
        .kb_data  (kb_data),
        .kb_wren  (kb_wren),
        .kbbuf_rd (kbbuf_rd),
        .keyb_rd  (keyb_rd)
    );

endmodule

/* include/tb_zbus_tasks.svh */
`ifndef TB_ZBUS_TASKS_SVH
`define TB_ZBUS_TASKS_SVH

////////////////////////////////////////////////////////////
// Random numbers and bus cycles
////////////////////////////////////////////////////////////
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

// One Z80 cycle with the strobe low for STB_LOW cycles and then idle for STB_GAP
task automatic strobe_cycle(input logic [ADDR_W-1:0] addr, input logic io, input logic wr,
                            input logic [DATA_W-1:0] data, input int kind);
    @(negedge clk);
    bus.a      = addr;
    bus.iorq_n = !io;
    bus.mreq_n = io;
    bus.wr_n   = !wr;
    bus.rd_n   = wr;
    d_in       = data;
    repeat (STB_SAMPLE - 1) @(negedge clk);
    if (kind != CHK_NONE) begin
        chk_kind = kind;
        n_requested++;
        -> check_now;
    end
    repeat (STB_LOW - STB_SAMPLE + 1) @(negedge clk);
    bus.rd_n   = 1'b1;          // Release everything together
    bus.wr_n   = 1'b1;
    bus.iorq_n = 1'b1;
    bus.mreq_n = 1'b1;
    repeat (STB_GAP - 1) @(negedge clk);
endtask

task automatic io_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    strobe_cycle(addr, 1'b1, 1'b1, data, CHK_NONE);
endtask

task automatic io_read(input logic [ADDR_W-1:0] addr, input logic oe,
                       input logic [DATA_W-1:0] data);
    exp_oe   = oe;
    exp_byte = data;
    strobe_cycle(addr, 1'b1, 1'b0, 8'h00, CHK_READ);
endtask

task automatic mem_cycle(input logic [ADDR_W-1:0] addr, input logic wr,
                         input logic [DATA_W-1:0] data, input mem_sel_t exp);
    exp_mem = exp;
    strobe_cycle(addr, 1'b0, wr, data, CHK_MEM);
endtask

// Single-cycle push from the keyboard side
task automatic kb_push(input logic [DATA_W-1:0] data);
    @(negedge clk);
    kb_data = data;
    kb_wren = 1'b1;
    @(negedge clk);
    kb_wren = 1'b0;
endtask

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////
task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %02h got %02h", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_mem(input string name, input mem_sel_t exp, input mem_sel_t act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected ram_ce_n=%b cart_ce_n=%b ram_we_n=%b ba=%0d",
                 $time, name, exp.ram_ce_n, exp.cart_ce_n, exp.ram_we_n, exp.ba);
        $display("     got ram_ce_n=%b cart_ce_n=%b ram_we_n=%b ba=%0d",
                 act.ram_ce_n, act.cart_ce_n, act.ram_we_n, act.ba);
        end_with_failure();
    end
endtask

`endif

/* tests/tb_zbus_top.sv */
`timescale 1ns/10ps

module tb_zbus_top
    import zbus_pkg::*;
();

    ////////////////////////////////////////////////////////////
    // Test lengths and bus timing
    ////////////////////////////////////////////////////////////
    localparam int STB_LOW    = 8;
    localparam int STB_GAP    = 4;
    localparam int STB_SAMPLE = 6;      // Low cycle where outputs are checked
    localparam int N_BANK     = 24;
    localparam int N_MEM      = 160;
    localparam int N_KEYB     = 24;
    localparam int N_IO       = 4;
    // Reset reads, bank loop, dis_regs sequence, memory, keys, FIFO, I/O bits
    localparam int N_BUS = 5 + 2*N_BANK + 13 + N_MEM + N_MEM/8 + N_KEYB + 54 + 6*N_IO;
    localparam int TIMEOUT_CYCLES = 12*N_BUS + 200;

    localparam int CHK_NONE = 0;
    localparam int CHK_READ = 1;
    localparam int CHK_MEM  = 2;
    localparam int CHK_OUTS = 3;

    logic                      clk;
    logic                      reset;
    bus_req_t                  bus;
    logic [DATA_W-1:0]         d_in;
    logic [KB_ROWS*DATA_W-1:0] keys;
    logic [DATA_W-1:0]         kb_data;
    logic                      kb_wren;
    logic                      cassette_in;
    logic                      printer_in;
    logic                      vblank;
    logic [DATA_W-1:0]         d_out;
    logic                      d_oe;
    mem_sel_t                  mem_sel;
    logic                      cassette_out;
    logic                      printer_out;
    logic                      cpm_remap;

    logic [31:0]       rng_state = 32'hf873da74;
    logic [31:0]       r;
    logic [1:0]        idx;
    logic [7:0]        ahi;
    bank_reg_t         bank_m [4];     // Bank registers as the CPU wrote them
    logic [DATA_W-1:0] fifo_m [$];

    // Expected values set before each check request
    int                chk_kind;
    logic              exp_oe;
    logic [DATA_W-1:0] exp_byte;
    mem_sel_t          exp_mem;
    logic [2:0]        exp_outs;        // cassette, printer, remap
    int                n_requested = 0;
    int                n_checked = 0;
    int                cycle_cnt = 0;
    event              check_now;

    zbus_top i_zbus_top (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .d_in         (d_in),
        .keys         (keys),
        .kb_data      (kb_data),
        .kb_wren      (kb_wren),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .vblank       (vblank),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .mem_sel      (mem_sel),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .cpm_remap    (cpm_remap)
    );

    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    `include "tb_zbus_tasks.svh"

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic mem_sel_t expect_mem(input bank_reg_t bank, input logic [15:0] a,
                                            input logic wr);
        mem_sel_t m;
        logic     sysram;
        logic     reserved;
        logic     allowed;
        logic     cart;
        logic     ram;
        sysram   = bank.overlay && a[13:11] == 3'd7;   // $3800-$3FFF
        reserved = bank.page <= PAGE_RES_ROM_LAST || bank.page == PAGE_RES_VRAM ||
                   bank.page == PAGE_RES_CHRAM || (bank.overlay && a[13:11] == 3'd6);
        allowed  = !sysram && !reserved && !(wr && bank.ro);
        cart     = allowed && bank.page >= 6'd16 && bank.page <= 6'd19;
        ram      = sysram || (allowed && bank.page >= 6'd32);
        m.ram_ce_n  = !ram;
        m.cart_ce_n = !cart;
        m.ram_we_n  = !(wr && ram);
        m.ba        = sysram ? 5'd0 : bank.page[4:0];
        return m;
    endfunction

    function automatic logic [7:0] expect_keys(input logic [63:0] k, input logic [7:0] hi);
        logic [7:0] res;
        res = 8'hFF;
        for (int i = 0; i < 8; i++) begin
            if (!hi[i]) res &= k[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_outputs(input logic [2:0] bits);
        @(negedge clk);
        exp_outs = bits;
        chk_kind = CHK_OUTS;
        n_requested++;
        -> check_now;
    endtask

    task automatic push_random_keys(input int n);
        logic [31:0]       rnd;
        logic [DATA_W-1:0] b;
        for (int i = 0; i < n; i++) begin
            rnd = next_rand();
            b   = rnd[15:8];
            kb_push(b);
            if (fifo_m.size() < KBBUF_DEPTH) fifo_m.push_back(b);   // Full FIFO drops it
        end
    endtask

    task automatic drain_kbbuf(input int n);
        for (int i = 0; i < n; i++) begin
            io_read({8'h5A, 8'hFA}, 1'b1, fifo_m.size() > 0 ? fifo_m.pop_front() : 8'h00);
        end
    endtask

    always #2 clk = ~clk;

    // Checker samples 1 ns after the drive edge
    always @(check_now) begin
        #1;
        case (chk_kind)
            CHK_READ: begin
                check_bit("d_oe", exp_oe, d_oe);
                if (exp_oe) check_byte("d_out", exp_byte, d_out);
            end
            CHK_MEM: check_mem("mem_sel", exp_mem, mem_sel);
            CHK_OUTS: begin
                check_bit("cassette_out", exp_outs[2], cassette_out);
                check_bit("printer_out", exp_outs[1], printer_out);
                check_bit("cpm_remap", exp_outs[0], cpm_remap);
                check_bit("d_oe", 1'b0, d_oe);
            end
            default: ;
        endcase
        n_checked++;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        bus         = '{a: 16'h0000, rd_n: 1'b1, wr_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1};
        d_in        = '0;
        keys        = '1;
        kb_data     = '0;
        kb_wren     = 1'b0;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        vblank      = 1'b0;
        bank_m[0]   = 8'hC0;
        bank_m[1]   = 8'd33;
        bank_m[2]   = 8'd34;
        bank_m[3]   = 8'd19;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        check_outputs(3'b000);
        for (int i = 0; i < 4; i++) io_read(16'h00F0 + 16'(i), 1'b1, bank_m[i]);
        io_read(16'h00FB, 1'b1, 8'h00);

        for (int i = 0; i < N_BANK; i++) begin
            r   = next_rand();
            idx = r[1:0];
            io_write({r[31:24], 8'hF0 | {6'b0, idx}}, r[15:8]);
            bank_m[idx] = r[15:8];
            io_read({r[23:16], 8'hF0 | {6'b0, idx}}, 1'b1, bank_m[idx]);
        end

        // dis_regs hides $F0-$F3 while dis_psgs only reads back
        io_write(16'h00FB, 8'h03);
        io_read(16'h00FB, 1'b1, 8'h03);
        io_write(16'h00F1, ~bank_m[1]);
        for (int i = 0; i < 4; i++) io_read(16'h00F0 + 16'(i), 1'b0, 8'h00);
        io_write(16'h00FB, 8'hFC);
        io_read(16'h00FB, 1'b1, 8'h04);
        for (int i = 0; i < 4; i++) io_read(16'h00F0 + 16'(i), 1'b1, bank_m[i]);

        for (int i = 0; i < N_MEM; i++) begin
            if (i % 8 == 0) begin
                r   = next_rand();
                idx = r[1:0];
                io_write({8'h00, 8'hF0 | {6'b0, idx}}, r[15:8]);
                bank_m[idx] = r[15:8];
            end
            r = next_rand();
            mem_cycle(r[15:0], r[16], r[31:24], expect_mem(bank_m[r[15:14]], r[15:0], r[16]));
        end

        for (int i = 0; i < N_KEYB; i++) begin
            r          = next_rand();
            keys[31:0] = next_rand();
            keys[63:32] = next_rand();
            ahi = (i == 0) ? 8'hFF : (i == 1) ? 8'h00 : r[7:0];
            io_read({ahi, 8'hFF}, 1'b1, expect_keys(keys, ahi));
        end

        drain_kbbuf(1);
        push_random_keys(5);
        drain_kbbuf(6);
        push_random_keys(3);
        io_write(16'h00FA, 8'h00);
        fifo_m.delete();
        drain_kbbuf(1);
        push_random_keys(20);
        drain_kbbuf(17);

        for (int i = 0; i < N_IO; i++) begin
            r = next_rand();
            io_write(16'h00FC, {r[15:9], r[0]});
            io_write(16'h00FE, {r[23:17], r[1]});
            io_write(16'h00FD, {r[31:25], r[2]});
            check_outputs({r[0], r[1], r[2]});
        end
        for (int i = 0; i < N_IO; i++) begin
            r           = next_rand();
            cassette_in = r[0];
            printer_in  = r[1];
            vblank      = r[2];
            repeat (8) @(negedge clk);
            io_read(16'h00FC, 1'b1, {7'b0, !r[0]});
            io_read(16'h00FD, 1'b1, {7'b0, !r[2]});
            io_read(16'h00FE, 1'b1, {7'b0, r[1]});
        end

        repeat (2) @(negedge clk);
        if (n_checked == n_requested) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Checker ran %0d of %0d requested checks", n_checked, n_requested);
            end_with_failure();
        end
    end

endmodule
